/* design/dcache_cfg_pkg.sv */
package dcache_cfg_pkg;

    // cache geometry
    localparam int nway           = 2;
    localparam int nset           = 256;
    localparam int line_bytes     = 16;
    localparam int words_per_line = 4;

    // split of a 32-bit byte address
    localparam int tag_w    = 20;
    localparam int index_w  = 8;
    localparam int offset_w = 4;

    // word-in-line select, the rest of the offset picks the byte
    localparam int word_w = $clog2(words_per_line);

    localparam int line_w = line_bytes * 8;

    // replacement lfsr, the seed must be nonzero
    localparam int                 lfsr_w    = 16;
    localparam logic [lfsr_w-1:0] lfsr_seed = 16'hace1;

endpackage

/* design/dcache_types_pkg.sv */
package dcache_types_pkg;
    import dcache_cfg_pkg::*;

    // one address word, seen either raw or as cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_w-1:0]           tag;
            logic [index_w-1:0]         index;
            logic [word_w-1:0]          word;
            logic [offset_w-word_w-1:0] byte_sel;
        } f;
    } cache_addr_u;

    // outstanding processor request
    typedef struct packed {
        logic        valid;
        cache_addr_u addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    // per-line tag entry
    typedef struct packed {
        logic             dirty;
        logic             valid;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    // write into one way, data bytes gated by be
    typedef struct packed {
        logic                  we;
        logic [index_w-1:0]    index;
        tag_entry_t            tag;
        logic [line_bytes-1:0] be;
        logic [line_w-1:0]     data;
    } way_wr_t;

    // miss command to the memory port
    typedef struct packed {
        logic              start;
        logic              dirty;
        cache_addr_u       wb_addr;
        logic [line_w-1:0] wb_line;
        cache_addr_u       rd_addr;
    } mem_cmd_t;

    // line-wide memory request
    typedef struct packed {
        logic              req;
        logic              we;
        logic [31:0]       addr;
        logic [line_w-1:0] wdata;
    } mem_bus_t;

endpackage

/* design/dcache_req_stage.sv */
`timescale 1ns/1ps

module dcache_req_stage
    import dcache_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        valid_i,
    input  logic [31:0] addr_i,
    input  logic [3:0]  wstrb_i,
    input  logic [31:0] wdata_i,
    input  logic        done_i,
    output cpu_req_t    req_o
);

    logic        valid_q;
    cache_addr_u addr_q;
    logic [3:0]  wstrb_q;
    logic [31:0] wdata_q;

    // a new strobe wins over the done of the previous request
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (valid_i) begin
            valid_q <= 1'b1;
        end else if (done_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            addr_q.raw <= addr_i;
            wstrb_q    <= wstrb_i;
            wdata_q    <= wdata_i;
        end
    end

    always_comb begin
        req_o.valid = valid_q;
        req_o.addr  = addr_q;
        req_o.wstrb = wstrb_q;
        req_o.wdata = wdata_q;
    end

endmodule

/* design/dcache_way.sv */
`timescale 1ns/1ps

module dcache_way
    import dcache_cfg_pkg::*;
    import dcache_types_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [index_w-1:0] rd_index_i,
    input  way_wr_t            wr_i,
    output tag_entry_t         tag_o,
    output logic [line_w-1:0]  line_o
);

    tag_entry_t        tag_q  [nset];
    logic [line_w-1:0] data_q [nset];

    // reset clears the valid and dirty bits of every line
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < nset; s++) begin
                tag_q[s].valid <= 1'b0;
                tag_q[s].dirty <= 1'b0;
            end
        end else if (wr_i.we) begin
            tag_q[wr_i.index] <= wr_i.tag;
        end
    end

    // byte-enabled line write
    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            for (int b = 0; b < line_bytes; b++) begin
                if (wr_i.be[b]) begin
                    data_q[wr_i.index][b*8 +: 8] <= wr_i.data[b*8 +: 8];
                end
            end
        end
    end

    // asynchronous read returns the old contents during a write
    assign tag_o  = tag_q[rd_index_i];
    assign line_o = data_q[rd_index_i];

endmodule

/* design/dcache_victim_lfsr.sv */
`timescale 1ns/1ps

module dcache_victim_lfsr
    import dcache_cfg_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic victim_o
);

    logic [lfsr_w-1:0] lfsr_q;
    logic              fb;

    // x^16 + x^14 + x^13 + x^11 + 1, maximal length
    assign fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= lfsr_seed;
        end else begin
            lfsr_q <= {lfsr_q[lfsr_w-2:0], fb};
        end
    end

    assign victim_o = lfsr_q[0];

endmodule

/* design/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_cfg_pkg::*;
    import dcache_types_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  cpu_req_t                    req_i,
    input  tag_entry_t [nway-1:0]       tags_i,
    input  logic [nway-1:0][line_w-1:0] lines_i,
    input  logic                        victim_i,
    input  logic                        refill_valid_i,
    input  logic [line_w-1:0]           refill_line_i,
    output logic [index_w-1:0]          rd_index_o,
    output way_wr_t [nway-1:0]          way_wr_o,
    output mem_cmd_t                    mem_cmd_o,
    output logic                        done_o,
    output logic                        data_ok_o,
    output logic [31:0]                 rdata_o
);

    typedef enum logic [1:0] {idle, lookup, refill_wait} state_e;

    state_e                state_q;
    state_e                state_n;
    state_e                state;
    logic                  victim_q;
    logic                  is_store;
    logic [nway-1:0]       hit_way;
    logic                  hit;
    logic                  hit_sel;
    logic [line_w-1:0]     hit_line;
    logic [line_bytes-1:0] st_be;
    logic [line_w-1:0]     st_line;
    logic [line_w-1:0]     refill_merged;

    assign is_store   = |req_i.wstrb;
    assign rd_index_o = req_i.addr.f.index;

    // a freshly captured request is looked up in its first cycle
    assign state = (state_q == idle && req_i.valid) ? lookup : state_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= idle;
        end else begin
            state_q <= state_n;
        end
    end

    always_comb begin
        state_n = state_q;
        case (state)
            lookup: begin
                state_n = hit ? idle : refill_wait;
            end
            refill_wait: begin
                if (refill_valid_i) begin
                    state_n = idle;
                end
            end
            default: begin
                state_n = idle;
            end
        endcase
    end

    // tag compare over both ways
    always_comb begin
        for (int i = 0; i < nway; i++) begin
            hit_way[i] = tags_i[i].valid && (tags_i[i].tag == req_i.addr.f.tag);
        end
    end

    assign hit      = |hit_way;
    assign hit_sel  = hit_way[1];
    assign hit_line = lines_i[hit_sel];

    // store bytes placed at their word in the line
    always_comb begin
        st_be = '0;
        st_be[req_i.addr.f.word*4 +: 4] = req_i.wstrb;
    end

    assign st_line = {words_per_line{req_i.wdata}};

    // refill line with any store bytes laid over it
    always_comb begin
        for (int b = 0; b < line_bytes; b++) begin
            refill_merged[b*8 +: 8] = st_be[b] ? st_line[b*8 +: 8] : refill_line_i[b*8 +: 8];
        end
    end

    // victim is frozen for the whole miss
    always_ff @(posedge clk) begin
        if (state == lookup && !hit) begin
            victim_q <= victim_i;
        end
    end

    always_comb begin
        for (int i = 0; i < nway; i++) begin
            way_wr_o[i]           = '0;
            way_wr_o[i].index     = req_i.addr.f.index;
            way_wr_o[i].tag.tag   = req_i.addr.f.tag;
            way_wr_o[i].tag.valid = 1'b1;
            if (state == lookup && hit_way[i] && is_store) begin
                // write hit, only the strobed bytes change
                way_wr_o[i].we        = 1'b1;
                way_wr_o[i].tag.dirty = 1'b1;
                way_wr_o[i].be        = st_be;
                way_wr_o[i].data      = st_line;
            end else if (state == refill_wait && refill_valid_i && victim_q == 1'(i)) begin
                way_wr_o[i].we        = 1'b1;
                way_wr_o[i].tag.dirty = is_store;
                way_wr_o[i].be        = '1;
                way_wr_o[i].data      = refill_merged;
            end
        end
    end

    // miss command, the memory port latches it on start
    always_comb begin
        mem_cmd_o                 = '0;
        mem_cmd_o.start           = (state == lookup) && !hit;
        mem_cmd_o.dirty           = tags_i[victim_i].valid && tags_i[victim_i].dirty;
        mem_cmd_o.wb_addr.f.tag   = tags_i[victim_i].tag;
        mem_cmd_o.wb_addr.f.index = req_i.addr.f.index;
        mem_cmd_o.wb_line         = lines_i[victim_i];
        mem_cmd_o.rd_addr.f.tag   = req_i.addr.f.tag;
        mem_cmd_o.rd_addr.f.index = req_i.addr.f.index;
    end

    // response, stores return zero
    always_comb begin
        data_ok_o = 1'b0;
        rdata_o   = '0;
        case (state)
            lookup: begin
                data_ok_o = hit;
                if (hit && !is_store) begin
                    rdata_o = hit_line[req_i.addr.f.word*32 +: 32];
                end
            end
            refill_wait: begin
                data_ok_o = refill_valid_i;
                if (refill_valid_i && !is_store) begin
                    rdata_o = refill_line_i[req_i.addr.f.word*32 +: 32];
                end
            end
            default: begin
            end
        endcase
    end

    assign done_o = data_ok_o;

endmodule

/* design/dcache_mem_port.sv */
`timescale 1ns/1ps

module dcache_mem_port
    import dcache_cfg_pkg::*;
    import dcache_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  mem_cmd_t          cmd_i,
    input  logic              mem_rdy_i,
    input  logic              mem_rvalid_i,
    input  logic              mem_bvalid_i,
    input  logic [line_w-1:0] mem_rdata_i,
    output mem_bus_t          mem_o,
    output logic              refill_valid_o,
    output logic [line_w-1:0] refill_line_o
);

    typedef enum logic [2:0] {idle, wb_req, wb_wait, rd_req, rd_wait} state_e;

    state_e   state_q;
    state_e   state_n;
    mem_cmd_t cmd_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= idle;
        end else begin
            state_q <= state_n;
        end
    end

    // held for the whole sequence so req fields stay stable
    always_ff @(posedge clk) begin
        if (state_q == idle && cmd_i.start) begin
            cmd_q <= cmd_i;
        end
    end

    always_comb begin
        state_n = state_q;
        case (state_q)
            idle: begin
                if (cmd_i.start) begin
                    // clean victims skip the write-back
                    state_n = cmd_i.dirty ? wb_req : rd_req;
                end
            end
            wb_req: begin
                if (mem_rdy_i) begin
                    state_n = wb_wait;
                end
            end
            wb_wait: begin
                if (mem_bvalid_i) begin
                    state_n = rd_req;
                end
            end
            rd_req: begin
                if (mem_rdy_i) begin
                    state_n = rd_wait;
                end
            end
            rd_wait: begin
                if (mem_rvalid_i) begin
                    state_n = idle;
                end
            end
            default: begin
                state_n = idle;
            end
        endcase
    end

    always_comb begin
        mem_o = '0;
        case (state_q)
            wb_req: begin
                mem_o.req   = 1'b1;
                mem_o.we    = 1'b1;
                mem_o.addr  = cmd_q.wb_addr.raw;
                mem_o.wdata = cmd_q.wb_line;
            end
            rd_req: begin
                mem_o.req  = 1'b1;
                mem_o.addr = cmd_q.rd_addr.raw;
            end
            default: begin
            end
        endcase
    end

    assign refill_valid_o = (state_q == rd_wait) && mem_rvalid_i;
    assign refill_line_o  = mem_rdata_i;

endmodule

/* design/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_cfg_pkg::*;
    import dcache_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // processor side
    input  logic              valid_i,
    input  logic [31:0]       addr_i,
    input  logic [3:0]        wstrb_i,
    input  logic [31:0]       wdata_i,
    output logic              data_ok_o,
    output logic [31:0]       rdata_o,
    // memory side
    output mem_bus_t          mem_o,
    input  logic              mem_rdy_i,
    input  logic              mem_rvalid_i,
    input  logic              mem_bvalid_i,
    input  logic [line_w-1:0] mem_rdata_i
);

    cpu_req_t                    req;
    logic                        done;
    logic [index_w-1:0]          rd_index;
    way_wr_t [nway-1:0]          way_wr;
    tag_entry_t [nway-1:0]       tags;
    logic [nway-1:0][line_w-1:0] lines;
    logic                        victim;
    mem_cmd_t                    mem_cmd;
    logic                        refill_valid;
    logic [line_w-1:0]           refill_line;

    dcache_req_stage u_req_stage (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .addr_i  (addr_i),
        .wstrb_i (wstrb_i),
        .wdata_i (wdata_i),
        .done_i  (done),
        .req_o   (req)
    );

    for (genvar w = 0; w < nway; w++) begin : g_way
        dcache_way u_way (
            .clk        (clk),
            .rst        (rst),
            .rd_index_i (rd_index),
            .wr_i       (way_wr[w]),
            .tag_o      (tags[w]),
            .line_o     (lines[w])
        );
    end

    dcache_victim_lfsr u_lfsr (
        .clk      (clk),
        .rst      (rst),
        .victim_o (victim)
    );

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req),
        .tags_i         (tags),
        .lines_i        (lines),
        .victim_i       (victim),
        .refill_valid_i (refill_valid),
        .refill_line_i  (refill_line),
        .rd_index_o     (rd_index),
        .way_wr_o       (way_wr),
        .mem_cmd_o      (mem_cmd),
        .done_o         (done),
        .data_ok_o      (data_ok_o),
        .rdata_o        (rdata_o)
    );

    dcache_mem_port u_mem_port (
        .clk            (clk),
        .rst            (rst),
        .cmd_i          (mem_cmd),
        .mem_rdy_i      (mem_rdy_i),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_bvalid_i   (mem_bvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .mem_o          (mem_o),
        .refill_valid_o (refill_valid),
        .refill_line_o  (refill_line)
    );

endmodule

/* dv/dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker
    import dcache_cfg_pkg::*;
    import dcache_types_pkg::*;
#(
    parameter logic [31:0] fill_pattern = 32'h0
) (
    input  logic              clk,
    input  logic              rst,
    // request under test
    input  logic              valid_i,
    input  logic              exp_hit_i,
    input  logic [31:0]       addr_i,
    input  logic [3:0]        wstrb_i,
    input  logic [31:0]       wdata_i,
    // watched DUT outputs and memory handshake
    input  logic              data_ok_i,
    input  logic [31:0]       rdata_i,
    input  mem_bus_t          mem_i,
    input  logic              mem_rdy_i,
    output int                checks_o,
    output int                errors_o
);

    // architectural word values and lines stored to since their last write-back
    logic [31:0] shadow      [logic [29:0]];
    bit          dirty_lines [logic [27:0]];

    int          n_checks = 0;
    int          n_errors = 0;
    logic        pending;
    int          wait_cycles;
    logic        saw_req;
    logic        cur_hit;
    logic [31:0] cur_addr;
    logic [3:0]  cur_wstrb;
    logic [31:0] cur_wdata;
    logic        stalled;
    mem_bus_t    prev_bus;

    assign checks_o = n_checks;
    assign errors_o = n_errors;

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow.exists(a[31:2])) begin
            return shadow[a[31:2]];
        end
        return {a[31:2], 2'b00} ^ fill_pattern;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        n_errors++;
        $display("%s", what);
    endtask

    task automatic check_accept();
        logic [27:0] la;
        la = mem_i.addr[31:4];
        if (mem_i.we) begin
            // the victim is a whole line in the set of the request
            compare_word("mem_o.addr", 32'(mem_i.addr[11:0]),
                         {20'h0, cur_addr[11:4], 4'h0});
            if (!dirty_lines.exists(la)) begin
                report_failure($sformatf("clean line at %h was written back", {la, 4'h0}));
            end else begin
                dirty_lines.delete(la);
            end
            for (int w = 0; w < words_per_line; w++) begin
                compare_word("mem_o.wdata", mem_i.wdata[w*32 +: 32],
                             shadow_word({la, 2'(w), 2'b00}));
            end
        end else begin
            // refill must fetch the line of the request
            compare_word("mem_o.addr", mem_i.addr, {cur_addr[31:4], 4'h0});
        end
    endtask

    task automatic finish_request();
        logic [31:0] w;
        if (cur_hit) begin
            compare_word("data_ok_o latency", wait_cycles, 1);
            if (saw_req) begin
                report_failure("a repeated load went to memory instead of hitting");
            end
        end
        if (|cur_wstrb) begin
            compare_word("rdata_o", rdata_i, 32'h0);
            w = shadow_word(cur_addr);
            for (int b = 0; b < 4; b++) begin
                if (cur_wstrb[b]) begin
                    w[b*8 +: 8] = cur_wdata[b*8 +: 8];
                end
            end
            shadow[cur_addr[31:2]]       = w;
            dirty_lines[cur_addr[31:4]] = 1'b1;
        end else begin
            compare_word("rdata_o", rdata_i, shadow_word(cur_addr));
        end
        pending = 1'b0;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            pending = 1'b0;
            stalled = 1'b0;
        end else begin
            // a stalled request keeps every field until accepted
            if (stalled) begin
                if (!mem_i.req) begin
                    report_failure("mem_o.req dropped before the memory accepted it");
                end else begin
                    compare_word("mem_o.we", 32'(mem_i.we), 32'(prev_bus.we));
                    compare_word("mem_o.addr", mem_i.addr, prev_bus.addr);
                    for (int w = 0; w < words_per_line; w++) begin
                        compare_word("mem_o.wdata", mem_i.wdata[w*32 +: 32],
                                     prev_bus.wdata[w*32 +: 32]);
                    end
                end
            end
            stalled  = mem_i.req && !mem_rdy_i;
            prev_bus = mem_i;

            if (mem_i.req && !pending) begin
                report_failure("memory request raised with no processor request outstanding");
            end
            if (mem_i.req && mem_rdy_i) begin
                check_accept();
            end

            if (pending) begin
                wait_cycles++;
                saw_req = saw_req | mem_i.req;
                if (data_ok_i) begin
                    finish_request();
                end
            end else if (data_ok_i) begin
                report_failure("data_ok_o pulsed with no request outstanding");
            end

            if (valid_i) begin
                pending     = 1'b1;
                wait_cycles = 0;
                saw_req     = 1'b0;
                cur_hit     = exp_hit_i;
                cur_addr    = addr_i;
                cur_wstrb   = wstrb_i;
                cur_wdata   = wdata_i;
            end
        end
    end

endmodule

/* dv/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb
    import dcache_cfg_pkg::*;
    import dcache_types_pkg::*;
();

    localparam int          clk_period     = 20;
    localparam int          rst_cycles     = 8;
    localparam int          nent           = 22;
    localparam int          rand_seed      = 55323;
    localparam int          timeout_cycles = nent * 40;
    localparam logic [31:0] fill_pattern   = 32'h5a3c_96e1;

    // op_reload repeats the previous address and must hit
    typedef enum logic [1:0] {op_load, op_reload, op_store} op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] data;
    } entry_t;

    logic              clk;
    logic              rst;
    logic              valid_i;
    logic [31:0]       addr_i;
    logic [3:0]        wstrb_i;
    logic [31:0]       wdata_i;
    logic              data_ok_o;
    logic [31:0]       rdata_o;
    mem_bus_t          mem_o;
    logic              mem_rdy_i;
    logic              mem_rvalid_i;
    logic              mem_bvalid_i;
    logic [line_w-1:0] mem_rdata_i;
    logic              exp_hit;
    int                n_checks;
    int                n_errors;
    integer            seed = rand_seed;

    entry_t            stim      [nent];
    logic [line_w-1:0] mem_lines [logic [27:0]];

    dcache_top DUT (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (valid_i),
        .addr_i       (addr_i),
        .wstrb_i      (wstrb_i),
        .wdata_i      (wdata_i),
        .data_ok_o    (data_ok_o),
        .rdata_o      (rdata_o),
        .mem_o        (mem_o),
        .mem_rdy_i    (mem_rdy_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_bvalid_i (mem_bvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    dcache_checker #(.fill_pattern(fill_pattern)) u_checker (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (valid_i),
        .exp_hit_i (exp_hit),
        .addr_i    (addr_i),
        .wstrb_i   (wstrb_i),
        .wdata_i   (wdata_i),
        .data_ok_i (data_ok_o),
        .rdata_i   (rdata_o),
        .mem_i     (mem_o),
        .mem_rdy_i (mem_rdy_i),
        .checks_o  (n_checks),
        .errors_o  (n_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        stim[0]  = '{op_load,   32'h0000_1230, 4'h0, 32'h0000_0000};
        stim[1]  = '{op_reload, 32'h0000_1230, 4'h0, 32'h0000_0000};
        stim[2]  = '{op_load,   32'h0000_1234, 4'h0, 32'h0000_0000};
        stim[3]  = '{op_store,  32'h0000_1238, 4'hf, 32'hdead_beef};
        stim[4]  = '{op_reload, 32'h0000_1238, 4'h0, 32'h0000_0000};
        stim[5]  = '{op_store,  32'h0000_2440, 4'h2, 32'h0000_5a00};
        stim[6]  = '{op_reload, 32'h0000_2440, 4'h0, 32'h0000_0000};
        stim[7]  = '{op_store,  32'h0000_244c, 4'hc, 32'ha5a5_0000};
        stim[8]  = '{op_reload, 32'h0000_244c, 4'h0, 32'h0000_0000};
        stim[9]  = '{op_store,  32'h0000_3560, 4'h3, 32'h0000_1234};
        stim[10] = '{op_reload, 32'h0000_3560, 4'h0, 32'h0000_0000};
        // three tags on index 0x7c force dirty evictions
        stim[11] = '{op_store,  32'h0001_07c0, 4'hf, 32'h1111_1111};
        stim[12] = '{op_store,  32'h0001_17c4, 4'hf, 32'h2222_2222};
        stim[13] = '{op_store,  32'h0001_27c8, 4'h1, 32'h0000_0033};
        stim[14] = '{op_load,   32'h0001_07c0, 4'h0, 32'h0000_0000};
        stim[15] = '{op_load,   32'h0001_17c4, 4'h0, 32'h0000_0000};
        stim[16] = '{op_load,   32'h0001_27c8, 4'h0, 32'h0000_0000};
        stim[17] = '{op_store,  32'h0001_07cc, 4'h6, 32'h00ab_cd00};
        stim[18] = '{op_load,   32'h0001_37c0, 4'h0, 32'h0000_0000};
        stim[19] = '{op_load,   32'h0001_07cc, 4'h0, 32'h0000_0000};
        stim[20] = '{op_reload, 32'h0001_07cc, 4'h0, 32'h0000_0000};
        stim[21] = '{op_load,   32'h0000_fff0, 4'h0, 32'h0000_0000};
    end

    function automatic logic [line_w-1:0] read_line(input logic [27:0] la);
        logic [line_w-1:0] l;
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (int w = 0; w < words_per_line; w++) begin
            l[w*32 +: 32] = {la, 2'(w), 2'b00} ^ fill_pattern;
        end
        return l;
    endfunction

    // memory model, one transfer at a time with random stalls and latency
    initial begin : mem_model
        logic [27:0] la;
        logic        is_wr;
        int          delay;
        mem_rdy_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_bvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(posedge clk);
            mem_rvalid_i <= 1'b0;
            mem_bvalid_i <= 1'b0;
            if (!rst && mem_o.req && mem_rdy_i) begin
                la    = mem_o.addr[31:4];
                is_wr = mem_o.we;
                if (is_wr) begin
                    mem_lines[la] = mem_o.wdata;
                end
                mem_rdy_i <= 1'b0;
                delay = 2 + ($unsigned($random(seed)) % 4);
                repeat (delay) @(posedge clk);
                if (is_wr) begin
                    mem_bvalid_i <= 1'b1;
                end else begin
                    mem_rvalid_i <= 1'b1;
                    mem_rdata_i  <= read_line(la);
                end
            end else begin
                mem_rdy_i <= ($unsigned($random(seed)) % 4) != 0;
            end
        end
    end

    initial begin : stimulus
        rst     = 1'b1;
        valid_i = 1'b0;
        addr_i  = '0;
        wstrb_i = '0;
        wdata_i = '0;
        exp_hit = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        for (int i = 0; i < nent; i++) begin
            @(posedge clk);
            valid_i <= 1'b1;
            addr_i  <= stim[i].addr;
            wstrb_i <= stim[i].wstrb;
            wdata_i <= stim[i].data;
            exp_hit <= (stim[i].op == op_reload);
            @(posedge clk);
            valid_i <= 1'b0;
            do begin
                @(posedge clk);
            end while (!data_ok_o);
        end
        repeat (4) @(posedge clk);
        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_cycles * clk_period);
        $display("timeout after %0d cycles, a request never completed", timeout_cycles);
        $display("checks %0d errors %0d", n_checks, n_errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* project.f */
design/dcache_cfg_pkg.sv
design/dcache_types_pkg.sv
design/dcache_req_stage.sv
design/dcache_way.sv
design/dcache_victim_lfsr.sv
design/dcache_ctrl.sv
design/dcache_mem_port.sv
design/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - design/dcache_cfg_pkg.sv
  - design/dcache_types_pkg.sv
  - design/dcache_req_stage.sv
  - design/dcache_way.sv
  - design/dcache_victim_lfsr.sv
  - design/dcache_ctrl.sv
  - design/dcache_mem_port.sv
  - design/dcache_top.sv
  - target: test
    files:
      - dv/dcache_checker.sv
      - dv/dcache_tb.sv
